/* hdl/MinTrgPkg.sv */
`default_nettype none

package minTrgPkg;

  // ADC lane layout of one stream word
  localparam int samplesPerWord = 8;
  localparam int laneWidth = 16;
  localparam int adcWidth = 12;

  // Bus widths
  localparam int tdataWidth = 128;
  localparam int doutWidth = 64;
  localparam int timeWidth = 48;

  // Pre-acquisition length up to 31 words
  localparam int delayCntWidth = 5;

  // Top byte of header and footer words
  localparam logic [7:0] headerMark = 8'hAA;
  localparam logic [7:0] footerMark = 8'h55;

  // One accepted stream word with its tags
  typedef struct packed {
    logic [tdataWidth-1:0] sampleWord;
    logic [timeWidth-1:0] timeStamp;
    logic hit;
  } trgBeatT;

  // Frame FIFO entry
  typedef struct packed {
    trgBeatT beat;
    logic first;
    logic last;
  } frameEntryT;

endpackage

`default_nettype wire

/* hdl/HitTrigger.sv */
`timescale 1ns/1ps
`default_nettype none

module HitTrigger #(
  parameter int postLen = 38
) (
  input logic clk,
  input logic rstN,
  input logic [minTrgPkg::tdataWidth-1:0] sTdata,
  input logic accept,
  input logic [minTrgPkg::delayCntWidth-1:0] preLen,
  input logic signed [minTrgPkg::adcWidth:0] thresholdVal,
  input logic signed [minTrgPkg::adcWidth-1:0] baseline,
  input logic [minTrgPkg::timeWidth-1:0] currentTime,
  output minTrgPkg::trgBeatT beat,
  output logic beatValid,
  output logic capture
);

  import minTrgPkg::*;

  // Big enough for the longest window preLen + postLen
  localparam int winWidth = $clog2((1 << delayCntWidth) + postLen);

  logic [samplesPerWord-1:0] laneHit;
  logic hitNow;
  logic [winWidth-1:0] winCnt;
  logic winOpen;

  // One compare per lane, all eight in parallel
  for (genvar i = 0; i < samplesPerWord; i++) begin : gLane
    logic signed [adcWidth-1:0] sample;
    logic signed [adcWidth:0] diff;

    assign sample = sTdata[i*laneWidth +: adcWidth];
    // Sign extended to 13 bits before the subtraction
    assign diff = sample - baseline;
    // Downward pulse below threshold
    assign laneHit[i] = diff < thresholdVal;
  end

  assign hitNow = |laneHit;
  assign winOpen = winCnt != '0;

  // Window counter and flags, all frozen while no word is accepted
  always_ff @(posedge clk) begin
    if (!rstN) begin
      winCnt <= '0;
      capture <= 1'b0;
      beatValid <= 1'b0;
    end else begin
      beatValid <= accept;
      if (accept) begin
        capture <= hitNow || winOpen;
        if (hitNow) begin
          // A later hit restarts the full window
          winCnt <= winWidth'(preLen) + winWidth'(postLen);
        end else if (winOpen) begin
          winCnt <= winCnt - 1'b1;
        end
      end
    end
  end

  // Tagged word
  always_ff @(posedge clk) begin
    if (accept) begin
      beat.sampleWord <= sTdata;
      beat.timeStamp <= currentTime;
      beat.hit <= hitNow;
    end
  end

  // Pre-acquisition length held while a window is open
  aPreLenSteady: assert property (
    @(posedge clk) disable iff (!rstN)
    winOpen |-> $stable(preLen)
  );

endmodule

`default_nettype wire

/* hdl/VariableDelay.sv */
`timescale 1ns/1ps
`default_nettype none

module VariableDelay #(
  parameter type payloadT = logic,
  parameter int depth = 32
) (
  input logic clk,
  input logic rstN,
  input logic [$clog2(depth)-1:0] delay,
  input payloadT inBeat,
  input logic inValid,
  input logic inFlag,
  output payloadT outBeat,
  output logic outValid,
  output logic outFlag
);

  // taps[k] holds the word from k+1 shifts ago
  payloadT taps [depth-1];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < depth - 1; i++) begin
        taps[i] <= '0;
      end
      outBeat <= '0;
      outValid <= 1'b0;
      outFlag <= 1'b0;
    end else begin
      outValid <= inValid;
      if (inValid) begin
        taps[0] <= inBeat;
        for (int i = 1; i < depth - 1; i++) begin
          taps[i] <= taps[i-1];
        end
        // Zero delay passes the current word
        if (delay == '0) begin
          outBeat <= inBeat;
        end else begin
          outBeat <= taps[delay - 1'b1];
        end
        // Flag is aligned but not delayed
        outFlag <= inFlag;
      end
    end
  end

  aDelayInRange: assert property (
    @(posedge clk) disable iff (!rstN)
    inValid |-> delay < depth
  );

endmodule

`default_nettype wire

/* hdl/FrameFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module FrameFifo #(
  parameter type payloadT = logic,
  parameter int depth = 16
) (
  input logic clk,
  input logic rstN,
  input payloadT wrData,
  input logic wrEn,
  input logic rdEn,
  output payloadT rdData,
  output logic rdValid,
  output logic [$clog2(depth+1)-1:0] freeCount
);

  localparam int addrWidth = $clog2(depth);
  localparam int cntWidth = $clog2(depth + 1);

  payloadT mem [depth];
  logic [addrWidth-1:0] wrPtr;
  logic [addrWidth-1:0] rdPtr;
  logic [cntWidth-1:0] count;

  // Wraps at depth, also for depths that are not a power of two
  function automatic logic [addrWidth-1:0] nextPtr(input logic [addrWidth-1:0] ptr);
    if (ptr == addrWidth'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (rdEn) begin
        rdPtr <= nextPtr(rdPtr);
      end
      if (wrEn && !rdEn) begin
        count <= count + 1'b1;
      end else if (rdEn && !wrEn) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrPtr] <= wrData;
    end
  end

  // Head of queue shown ahead of the pop
  assign rdData = mem[rdPtr];
  assign rdValid = count != '0;
  assign freeCount = cntWidth'(depth) - count;

  aNoOverflow: assert property (
    @(posedge clk) disable iff (!rstN)
    wrEn |-> count != cntWidth'(depth)
  );

  aNoUnderflow: assert property (
    @(posedge clk) disable iff (!rstN)
    rdEn |-> count != '0
  );

endmodule

`default_nettype wire

/* hdl/FrameBuilder.sv */
`timescale 1ns/1ps
`default_nettype none

module FrameBuilder #(
  parameter logic [7:0] channelId = 8'd0,
  parameter int maxFrameWords = 200,
  parameter int fifoDepth = 16
) (
  input logic clk,
  input logic rstN,
  input minTrgPkg::trgBeatT dlyBeat,
  input logic dlyValid,
  input logic dlyCapture,
  input logic mTready,
  output logic inReady,
  output logic [minTrgPkg::doutWidth-1:0] mTdata,
  output logic mTvalid,
  output logic mTlast
);

  import minTrgPkg::*;

  localparam int freeWidth = $clog2(fifoDepth + 1);
  localparam int wordCntWidth = $clog2(maxFrameWords + 1);

  typedef enum logic [1:0] {sHeader, sLow, sHigh, sFooter} stateT;

  frameEntryT held;
  logic heldValid;
  logic [wordCntWidth-1:0] wordCnt;
  logic [wordCntWidth-1:0] wordCntNext;
  logic atLimit;
  frameEntryT wrData;
  logic wrEn;
  frameEntryT head;
  logic rdValid;
  logic rdEn;
  logic [freeWidth-1:0] freeCount;
  logic outOfReset;
  stateT state;
  logic [15:0] dataCnt;
  logic [31:0] hitCnt;

  assign wordCntNext = wordCnt + 1'b1;
  assign atLimit = wordCntNext == wordCntWidth'(maxFrameWords);

  // Write side, one entry of look-behind so the gap can close a frame
  always_ff @(posedge clk) begin
    if (!rstN) begin
      heldValid <= 1'b0;
      wordCnt <= '0;
      outOfReset <= 1'b0;
    end else begin
      outOfReset <= 1'b1;
      if (dlyValid) begin
        heldValid <= dlyCapture;
        if (!dlyCapture || atLimit) begin
          wordCnt <= '0;
        end else begin
          wordCnt <= wordCntNext;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dlyValid && dlyCapture) begin
      held.beat <= dlyBeat;
      held.first <= wordCnt == '0;
      held.last <= atLimit;
    end
  end

  // Held entry leaves with the next delayed word
  assign wrEn = dlyValid && heldValid;

  always_comb begin
    wrData = held;
    wrData.last = held.last || !dlyCapture;
  end

  // Room for the words already in the trigger and delay stages
  assign inReady = outOfReset && (freeCount >= freeWidth'(3));

  FrameFifo #(
    .payloadT(frameEntryT),
    .depth(fifoDepth)
  ) entryFifo (
    .clk(clk),
    .rstN(rstN),
    .wrData(wrData),
    .wrEn(wrEn),
    .rdEn(rdEn),
    .rdData(head),
    .rdValid(rdValid),
    .freeCount(freeCount)
  );

  // Read side serializer
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= sHeader;
      dataCnt <= '0;
      hitCnt <= '0;
    end else if (mTvalid && mTready) begin
      unique case (state)
        sHeader: state <= sLow;
        sLow: state <= sHigh;
        sHigh: begin
          dataCnt <= dataCnt + 1'b1;
          hitCnt <= hitCnt + 32'(head.beat.hit);
          state <= head.last ? sFooter : sLow;
        end
        sFooter: begin
          dataCnt <= '0;
          hitCnt <= '0;
          state <= sHeader;
        end
      endcase
    end
  end

  // Entry is popped once its high half is taken
  assign rdEn = (state == sHigh) && mTvalid && mTready;

  always_comb begin
    mTvalid = rdValid;
    mTlast = 1'b0;
    mTdata = '0;
    unique case (state)
      sHeader: mTdata = {headerMark, channelId, head.beat.timeStamp};
      sLow: mTdata = head.beat.sampleWord[doutWidth-1:0];
      sHigh: mTdata = head.beat.sampleWord[tdataWidth-1:doutWidth];
      sFooter: begin
        // Counts are final, nothing from the FIFO needed
        mTvalid = 1'b1;
        mTlast = 1'b1;
        mTdata = {footerMark, channelId, dataCnt, hitCnt};
      end
    endcase
  end

  aOutputHeld: assert property (
    @(posedge clk) disable iff (!rstN)
    mTvalid && !mTready |=> mTvalid && $stable(mTdata) && $stable(mTlast)
  );

  aHeaderOnFirst: assert property (
    @(posedge clk) disable iff (!rstN)
    (state == sHeader) && rdValid |-> head.first
  );

endmodule

`default_nettype wire

/* hdl/MinimumTrigger.sv */
`timescale 1ns/1ps
`default_nettype none

module MinimumTrigger #(
  parameter logic [7:0] channelId = 8'd0,
  parameter int postLen = 38,
  parameter int maxFrameWords = 200,
  parameter int fifoDepth = 16
) (
  input logic clk,
  input logic rstN,
  input logic [minTrgPkg::tdataWidth-1:0] sTdata,
  input logic sTvalid,
  output logic sTready,
  input logic [minTrgPkg::delayCntWidth-1:0] preLen,
  input logic signed [minTrgPkg::adcWidth:0] thresholdVal,
  input logic signed [minTrgPkg::adcWidth-1:0] baseline,
  input logic [minTrgPkg::timeWidth-1:0] currentTime,
  output logic [minTrgPkg::doutWidth-1:0] mTdata,
  output logic mTvalid,
  input logic mTready,
  output logic mTlast
);

  import minTrgPkg::*;

  // One tap per possible preLen value
  localparam int delayDepth = 1 << delayCntWidth;

  logic accept;
  trgBeatT beat;
  logic beatValid;
  logic capture;
  trgBeatT dlyBeat;
  logic dlyValid;
  logic dlyCapture;

  assign accept = sTvalid && sTready;

  HitTrigger #(
    .postLen(postLen)
  ) trigger (
    .clk(clk),
    .rstN(rstN),
    .sTdata(sTdata),
    .accept(accept),
    .preLen(preLen),
    .thresholdVal(thresholdVal),
    .baseline(baseline),
    .currentTime(currentTime),
    .beat(beat),
    .beatValid(beatValid),
    .capture(capture)
  );

  // Pre-acquisition delay
  VariableDelay #(
    .payloadT(trgBeatT),
    .depth(delayDepth)
  ) preAcquiDelay (
    .clk(clk),
    .rstN(rstN),
    .delay(preLen),
    .inBeat(beat),
    .inValid(beatValid),
    .inFlag(capture),
    .outBeat(dlyBeat),
    .outValid(dlyValid),
    .outFlag(dlyCapture)
  );

  FrameBuilder #(
    .channelId(channelId),
    .maxFrameWords(maxFrameWords),
    .fifoDepth(fifoDepth)
  ) frameGen (
    .clk(clk),
    .rstN(rstN),
    .dlyBeat(dlyBeat),
    .dlyValid(dlyValid),
    .dlyCapture(dlyCapture),
    .mTready(mTready),
    .inReady(sTready),
    .mTdata(mTdata),
    .mTvalid(mTvalid),
    .mTlast(mTlast)
  );

endmodule

`default_nettype wire

/* test/MinimumTriggerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module MinimumTriggerTb;

  localparam logic [7:0] chanId = 8'h3C;
  localparam int postLen = 38;
  localparam int maxWords = 200;

  // One expected output word
  typedef struct packed {
    logic [63:0] data;
    logic last;
  } expWordT;

  // Accepted input word as the model remembers it
  typedef struct packed {
    logic [127:0] data;
    logic [47:0] stamp;
    logic hit;
  } histWordT;

  logic clk;
  logic rstN;
  logic [127:0] sTdata;
  logic sTvalid;
  logic sTready;
  logic [4:0] preLen;
  logic signed [12:0] thresholdVal;
  logic signed [11:0] baseline;
  logic [47:0] currentTime;
  logic [63:0] mTdata;
  logic mTvalid;
  logic mTready;
  logic mTlast;

  expWordT expQ [$];
  histWordT history [$];
  expWordT want;
  string testName;
  int errors;
  int outWords;
  int winCnt;
  int frameWords;
  int frameHits;
  int stallCycles;
  int waitCycles;
  logic throttle;
  logic gaps;
  logic [31:0] seedDummy;

  MinimumTrigger #(
    .channelId(chanId),
    .postLen(postLen),
    .maxFrameWords(maxWords),
    .fifoDepth(16)
  ) DUT (
    .clk(clk),
    .rstN(rstN),
    .sTdata(sTdata),
    .sTvalid(sTvalid),
    .sTready(sTready),
    .preLen(preLen),
    .thresholdVal(thresholdVal),
    .baseline(baseline),
    .currentTime(currentTime),
    .mTdata(mTdata),
    .mTvalid(mTvalid),
    .mTready(mTready),
    .mTlast(mTlast)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    currentTime <= currentTime + 48'd1;
  end

  // Sink ready, low about 30% of cycles when throttled
  always @(posedge clk) begin
    if (throttle) begin
      mTready <= ($urandom % 10) >= 3;
    end else begin
      mTready <= 1'b1;
    end
  end

  // Output checker
  always @(posedge clk) begin
    if (rstN && mTvalid && mTready) begin
      outWords++;
      if (expQ.size() == 0) begin
        errors++;
        $display("Output word %h arrived while no word was expected (%s)", mTdata, testName);
      end else begin
        want = expQ.pop_front();
        if (mTdata !== want.data) begin
          errors++;
          $display("** Error [%s] mTdata: expected %h, actual %h", testName, want.data, mTdata);
        end
        if (mTlast !== want.last) begin
          errors++;
          $display("** Error [%s] mTlast: expected %b, actual %b", testName, want.last, mTlast);
        end
      end
      if (mTlast && mTdata[63:56] != 8'h55) begin
        errors++;
        $display("mTlast was set on a word that is not a footer (%s)", testName);
      end
    end
  end

  // Minimum trigger rule, any lane below threshold after baseline removal
  function automatic logic wordHits(input logic [127:0] word);
    logic signed [11:0] sample;
    for (int i = 0; i < 8; i++) begin
      sample = word[i*16 +: 12];
      if (int'(sample) - int'(baseline) < int'(thresholdVal)) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Noise around baseline, one deep pulse on a random lane for a hit
  function automatic logic [127:0] makeWord(input logic withHit);
    logic [127:0] word;
    int noise;
    int lane;
    for (int i = 0; i < 8; i++) begin
      noise = int'($urandom % 101) - 50;
      word[i*16 +: 16] = {4'($urandom), 12'(int'(baseline) + noise)};
    end
    if (withHit) begin
      lane = int'($urandom % 8);
      word[lane*16 +: 12] = 12'(int'(baseline) - 300 - int'($urandom % 400));
    end
    return word;
  endfunction

  task automatic pushWord(input logic [63:0] data, input logic last);
    expWordT item;
    item.data = data;
    item.last = last;
    expQ.push_back(item);
  endtask

  task automatic closeFrame();
    pushWord({8'h55, chanId, 16'(frameWords), 32'(frameHits)}, 1'b1);
    frameWords = 0;
    frameHits = 0;
  endtask

  // Reference model, one call per accepted word
  task automatic modelAccept(input logic [127:0] word, input logic [47:0] stamp);
    histWordT cur;
    histWordT old;
    logic capture;
    int idx;
    cur.data = word;
    cur.stamp = stamp;
    cur.hit = wordHits(word);
    history.push_back(cur);
    capture = cur.hit || winCnt != 0;
    if (cur.hit) begin
      winCnt = int'(preLen) + postLen;
    end else if (winCnt != 0) begin
      winCnt--;
    end
    if (capture) begin
      idx = history.size() - 1 - int'(preLen);
      old = '0;
      if (idx >= 0) begin
        old = history[idx];
      end
      if (frameWords == 0) begin
        pushWord({8'hAA, chanId, old.stamp}, 1'b0);
      end
      pushWord(old.data[63:0], 1'b0);
      pushWord(old.data[127:64], 1'b0);
      frameWords++;
      frameHits += int'(old.hit);
      if (frameWords == maxWords) begin
        closeFrame();
      end
    end else if (frameWords != 0) begin
      closeFrame();
    end
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Checked %0d output words, %0d errors", outWords, errors + 1);
    $display("Test failed");
    $finish;
  endtask

  // Holds the word until accepted
  task automatic sendWord(input logic [127:0] word);
    int cycles;
    logic taken;
    if (gaps && ($urandom % 10) == 0) begin
      sTvalid <= 1'b0;
      @(posedge clk);
    end
    sTdata <= word;
    sTvalid <= 1'b1;
    cycles = 0;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      if (sTready) begin
        taken = 1'b1;
        modelAccept(word, currentTime);
      end else begin
        stallCycles++;
        cycles++;
        if (cycles > 2000) begin
          abortRun("Timeout: an input word was never accepted");
        end
      end
    end
  endtask

  task automatic sendQuiet(input int count);
    for (int i = 0; i < count; i++) begin
      sendWord(makeWord(1'b0));
    end
  endtask

  initial begin
    seedDummy = $urandom(32'he1b29c10);
    clk = 1'b0;
    rstN = 1'b0;
    sTdata = '0;
    sTvalid = 1'b0;
    preLen = '0;
    thresholdVal = -13'sd250;
    baseline = 12'(int'($urandom % 401) - 200);
    currentTime = {16'($urandom), 32'($urandom)};
    mTready = 1'b1;
    throttle = 1'b0;
    gaps = 1'b0;
    errors = 0;
    outWords = 0;
    winCnt = 0;
    frameWords = 0;
    frameHits = 0;
    stallCycles = 0;
    testName = "reset";
    repeat (10) @(posedge clk);
    rstN <= 1'b1;

    testName = "quiet noise";
    sendQuiet(500);

    testName = "isolated hits";
    for (int k = 0; k < 6; k++) begin
      sendQuiet(80);
      preLen <= 5'($urandom % 32);
      sendWord(makeWord(1'b1));
    end

    // Hit spacing below the shortest window keeps it open
    testName = "window extension";
    for (int k = 0; k < 3; k++) begin
      sendQuiet(80);
      preLen <= 5'($urandom % 32);
      for (int j = 0; j < 4; j++) begin
        sendWord(makeWord(1'b1));
        sendQuiet(5 + int'($urandom % 34));
      end
    end

    testName = "long capture";
    sendQuiet(80);
    preLen <= 5'($urandom % 32);
    for (int k = 0; k < 450; k++) begin
      sendWord(makeWord(1'b1));
    end

    testName = "back-pressure";
    sendQuiet(80);
    preLen <= 5'($urandom % 32);
    throttle <= 1'b1;
    gaps = 1'b1;
    stallCycles = 0;
    for (int k = 0; k < 800; k++) begin
      sendWord(makeWord(($urandom % 40) == 0));
    end
    sendQuiet(100);
    if (stallCycles == 0) begin
      errors++;
      $display("Input ready never dropped while the output was throttled");
    end

    // Drain what is left in the FIFO
    sTvalid <= 1'b0;
    waitCycles = 0;
    while (expQ.size() != 0) begin
      @(posedge clk);
      waitCycles++;
      if (waitCycles > 5000) begin
        abortRun("Timeout: expected output words never arrived");
      end
    end
    throttle <= 1'b0;
    repeat (20) @(posedge clk);
    if (mTvalid) begin
      errors++;
      $display("Output still valid after every expected word was seen");
    end

    $display("Checked %0d output words, %0d errors", outWords, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/MinTrgPkg.sv
hdl/HitTrigger.sv
hdl/VariableDelay.sv
hdl/FrameFifo.sv
hdl/FrameBuilder.sv
hdl/MinimumTrigger.sv
test/MinimumTriggerTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module MinimumTriggerTb \
  && ./obj_dir/VMinimumTriggerTb | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
